/* source/light_grid_pkg.sv */
package light_grid_pkg;

    // ##########################################################
    // Grid geometry and bus constants
    // ##########################################################

    localparam int bank_width = 32;         // Lights per RAM word.

    typedef logic [15:0] pos_t;
    typedef logic [7:0]  reg_addr_t;

    localparam logic [1:0] axi_resp_okay = 2'b00;

    // Register map.
    localparam reg_addr_t reg_start   = 8'h00;
    localparam reg_addr_t reg_end     = 8'h04;
    localparam reg_addr_t reg_command = 8'h08;   // Write pushes an instruction.
    localparam reg_addr_t reg_status  = 8'h0C;
    localparam reg_addr_t reg_count   = 8'h10;

    localparam int status_done_bit = 0;
    localparam int status_busy_bit = 1;

    // ##########################################################
    // Instruction and register word types
    // ##########################################################

    typedef enum logic [1:0] {
        op_off    = 2'b00,
        op_toggle = 2'b01,
        op_on     = 2'b11
    } grid_op_t;

    typedef struct packed {
        logic     last;
        grid_op_t op;
        pos_t     start_row;
        pos_t     start_col;
        pos_t     end_row;
        pos_t     end_col;
    } grid_instr_t;

    typedef struct packed {
        pos_t row;
        pos_t col;
    } corner_word_t;

    typedef struct packed {
        logic [28:0] pad;
        logic        last;                 // Ends the run.
        grid_op_t    op;
    } command_word_t;

    // Same 32-bit write word, meaning picked by address.
    typedef union packed {
        corner_word_t  corner;
        command_word_t command;
    } reg_word_t;

endpackage

/* source/light_grid_ram.sv */
module light_grid_ram #(
    parameter int addr_width = 6,
    parameter int data_width = 32
) (
    input  logic                  clk,
    // Port A read/write
    input  logic                  wea,
    input  logic [addr_width-1:0] addra,
    input  logic [data_width-1:0] dia,
    output logic [data_width-1:0] doa,
    // Port B read-only
    input  logic [addr_width-1:0] addrb,
    output logic [data_width-1:0] dob
);

    logic [data_width-1:0] mem [2**addr_width];

    always_ff @(posedge clk) begin
        if (wea) begin
            mem[addra] <= dia;
        end
        doa <= mem[addra];       // Read-first.
    end

    always_ff @(posedge clk) begin
        dob <= mem[addrb];
    end

endmodule

/* source/instr_fifo.sv */
module instr_fifo #(
    parameter int depth = 4
) (
    input  logic                        clk,
    input  logic                        reset,
    input  light_grid_pkg::grid_instr_t in_instr,
    input  logic                        in_valid,
    output logic                        in_ready,
    output light_grid_pkg::grid_instr_t out_instr,
    output logic                        out_valid,
    input  logic                        out_ready
);
    import light_grid_pkg::*;

    localparam int ptr_width  = (depth > 1) ? $clog2(depth) : 1;
    localparam int fill_width = $clog2(depth + 1);

    grid_instr_t           mem [depth];
    logic [ptr_width-1:0]  wr_ptr;
    logic [ptr_width-1:0]  rd_ptr;
    logic [fill_width-1:0] fill;
    logic                  push;
    logic                  pop;

    assign in_ready  = (fill != fill_width'(depth));
    assign out_valid = (fill != '0);
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_instr = mem[rd_ptr];   // Head entry, held in flops.

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;                       // Both or neither, level unchanged.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_instr;
        end
    end

endmodule

/* source/axil_instr_port.sv */
module axil_instr_port #(
    parameter int result_width = 13
) (
    input  logic                        clk,
    input  logic                        reset,
    // AXI4-Lite write channels
    input  light_grid_pkg::reg_addr_t   awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [31:0]                 wdata,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    // AXI4-Lite read channels
    input  light_grid_pkg::reg_addr_t   araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [31:0]                 rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    // Instruction stream
    output light_grid_pkg::grid_instr_t instr,
    output logic                        instr_valid,
    input  logic                        instr_ready,
    // Engine status
    input  logic                        count_done,
    input  logic [result_width-1:0]     count_value,
    input  logic                        busy
);
    import light_grid_pkg::*;

    corner_word_t start_corner;
    corner_word_t end_corner;
    reg_word_t    wword;
    logic         write_idle;
    logic         write_take;
    logic         read_take;
    logic [31:0]  read_word;

    // ##########################################################
    // Write path
    // ##########################################################

    assign wword      = wdata;
    assign write_idle = !bvalid && !instr_valid;   // No response or push pending.
    assign awready    = write_idle && wvalid;      // AW and W are taken together.
    assign wready     = write_idle && awvalid;
    assign write_take = awvalid && awready;
    assign bresp      = axi_resp_okay;

    always_ff @(posedge clk) begin
        if (reset) begin
            bvalid      <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (instr_valid && instr_ready) begin
                instr_valid <= 1'b0;
                bvalid      <= 1'b1;               // Respond only once the FIFO took it.
            end
            if (write_take) begin
                if (awaddr == reg_command) begin
                    instr_valid <= 1'b1;
                end else begin
                    bvalid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (write_take) begin
            case (awaddr)
                reg_start: start_corner <= wword.corner;
                reg_end:   end_corner   <= wword.corner;
                reg_command: begin
                    instr.last      <= wword.command.last;
                    instr.op        <= wword.command.op;
                    instr.start_row <= start_corner.row;
                    instr.start_col <= start_corner.col;
                    instr.end_row   <= end_corner.row;
                    instr.end_col   <= end_corner.col;
                end
                default: ;
            endcase
        end
    end

    // ##########################################################
    // Read path
    // ##########################################################

    assign arready   = !rvalid;
    assign read_take = arvalid && arready;
    assign rresp     = axi_resp_okay;

    always_comb begin
        read_word = '0;
        case (araddr)
            reg_start: read_word = start_corner;
            reg_end:   read_word = end_corner;
            reg_status: begin
                read_word[status_done_bit] = count_done;
                read_word[status_busy_bit] = busy;
            end
            reg_count: read_word = 32'(count_value);
            default:   read_word = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid <= 1'b0;
        end else if (read_take) begin
            rvalid <= 1'b1;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (read_take) begin
            rdata <= read_word;
        end
    end

endmodule

/* source/light_display.sv */
module light_display #(
    parameter int grid_rows    = 64,
    parameter int grid_cols    = 96,
    parameter int result_width = 13
) (
    input  logic                        clk,
    input  logic                        reset,
    input  light_grid_pkg::grid_instr_t instr,
    input  logic                        instr_valid,
    output logic                        instr_ready,
    output logic                        count_done,
    output logic [result_width-1:0]     count_value,
    output logic                        busy
);
    import light_grid_pkg::*;

    localparam int bank_count  = (grid_cols + bank_width - 1) / bank_width;
    localparam int addr_width  = (grid_rows > 1) ? $clog2(grid_rows) : 1;
    localparam int sweep_width = $clog2(grid_rows + 3);
    localparam int pop_width   = $clog2(bank_width + 1);

    typedef enum logic [2:0] {
        st_clear,
        st_idle,
        st_read,
        st_write,
        st_count,
        st_done
    } state_t;

    state_t                                 state;
    grid_instr_t                            cur;
    logic [addr_width-1:0]                  row;
    logic [sweep_width-1:0]                 sweep;
    logic                                   ram_we;
    logic [bank_count-1:0][bank_width-1:0]  ram_rdata;
    logic [bank_count-1:0][bank_width-1:0]  ram_wdata;
    logic [bank_count-1:0][bank_width-1:0]  ram_rowb;
    logic [bank_count-1:0][bank_width-1:0]  bank_mask;
    logic [bank_count-1:0][pop_width-1:0]   bank_pop;
    logic [result_width-1:0]                bank_sum;
    logic                                   fetch_valid;
    logic                                   pop_valid;

    assign instr_ready = (state == st_idle);
    assign count_done  = (state == st_done);
    assign busy        = (state != st_idle) && (state != st_done);

    // ##########################################################
    // Control FSM
    // ##########################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_clear;
            row   <= '0;
            sweep <= '0;
        end else begin
            case (state)
                st_clear: begin
                    row <= row + 1'b1;
                    if (row == addr_width'(grid_rows - 1)) begin
                        state <= st_idle;
                    end
                end
                st_idle: begin
                    if (instr_valid) begin
                        row   <= addr_width'(instr.start_row);
                        state <= st_read;
                    end
                end
                st_read: state <= st_write;
                st_write: begin
                    if (row == addr_width'(cur.end_row)) begin
                        state <= cur.last ? st_count : st_idle;
                    end else begin
                        row   <= row + 1'b1;
                        state <= st_read;
                    end
                end
                st_count: begin
                    sweep <= sweep + 1'b1;
                    if (sweep == sweep_width'(grid_rows + 2)) begin
                        state <= st_done;      // Pipeline has drained.
                    end
                end
                default: ;                     // Done holds until reset.
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && instr_valid) begin
            cur <= instr;
        end
    end

    // ##########################################################
    // Row update
    // ##########################################################

    always_comb begin
        for (int b = 0; b < bank_count; b++) begin
            for (int j = 0; j < bank_width; j++) begin
                bank_mask[b][j] = (b * bank_width + j >= int'(cur.start_col)) &&
                                  (b * bank_width + j <= int'(cur.end_col));
            end
        end
    end

    always_comb begin
        for (int b = 0; b < bank_count; b++) begin
            case (cur.op)
                op_on:     ram_wdata[b] = ram_rdata[b] | bank_mask[b];
                op_off:    ram_wdata[b] = ram_rdata[b] & ~bank_mask[b];
                op_toggle: ram_wdata[b] = ram_rdata[b] ^ bank_mask[b];
                default:   ram_wdata[b] = ram_rdata[b];
            endcase
            if (state == st_clear) begin
                ram_wdata[b] = '0;
            end
        end
    end

    // No writes while reset is held.
    assign ram_we = !reset && (state == st_clear || state == st_write);

    // ##########################################################
    // Banks and count sweep
    // ##########################################################

    for (genvar b = 0; b < bank_count; b++) begin : g_bank
        light_grid_ram #(
            .addr_width(addr_width),
            .data_width(bank_width)
        ) u_ram (
            .clk  (clk),
            .wea  (ram_we),
            .addra(row),
            .dia  (ram_wdata[b]),
            .doa  (ram_rdata[b]),
            .addrb(addr_width'(sweep)),
            .dob  (ram_rowb[b])
        );

        always_ff @(posedge clk) begin
            bank_pop[b] <= pop_width'($countones(ram_rowb[b]));
        end
    end

    always_comb begin
        bank_sum = '0;
        for (int b = 0; b < bank_count; b++) begin
            bank_sum = bank_sum + result_width'(bank_pop[b]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid <= 1'b0;
            pop_valid   <= 1'b0;
            count_value <= '0;
        end else begin
            fetch_valid <= (state == st_count) && (sweep < sweep_width'(grid_rows));
            pop_valid   <= fetch_valid;
            if (pop_valid) begin
                count_value <= count_value + bank_sum;
            end
        end
    end

endmodule

/* source/light_grid_top.sv */
module light_grid_top #(
    parameter int grid_rows  = 64,
    parameter int grid_cols  = 96,
    parameter int fifo_depth = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  light_grid_pkg::reg_addr_t awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [31:0]               wdata,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  light_grid_pkg::reg_addr_t araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready
);
    import light_grid_pkg::*;

    localparam int result_width = $clog2(grid_rows * grid_cols + 1);

    grid_instr_t             port_instr;
    logic                    port_valid;
    logic                    port_ready;
    grid_instr_t             fifo_instr;
    logic                    fifo_valid;
    logic                    fifo_ready;
    logic                    count_done;
    logic [result_width-1:0] count_value;
    logic                    busy;

    axil_instr_port #(
        .result_width(result_width)
    ) u_port (
        .clk        (clk),
        .reset      (reset),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .instr      (port_instr),
        .instr_valid(port_valid),
        .instr_ready(port_ready),
        .count_done (count_done),
        .count_value(count_value),
        .busy       (busy)
    );

    instr_fifo #(
        .depth(fifo_depth)
    ) u_fifo (
        .clk      (clk),
        .reset    (reset),
        .in_instr (port_instr),
        .in_valid (port_valid),
        .in_ready (port_ready),
        .out_instr(fifo_instr),
        .out_valid(fifo_valid),
        .out_ready(fifo_ready)
    );

    light_display #(
        .grid_rows   (grid_rows),
        .grid_cols   (grid_cols),
        .result_width(result_width)
    ) u_display (
        .clk        (clk),
        .reset      (reset),
        .instr      (fifo_instr),
        .instr_valid(fifo_valid),
        .instr_ready(fifo_ready),
        .count_done (count_done),
        .count_value(count_value),
        .busy       (busy)
    );

endmodule

/* test/light_grid_assertions.sv */
module light_grid_assertions (
    input logic                        clk,
    input logic                        reset,
    input light_grid_pkg::grid_instr_t instr,
    input logic                        instr_valid,
    input logic                        instr_ready,
    input logic                        count_done
);
    timeunit 1ns;
    timeprecision 1ps;

    int   failures = 0;
    logic last_taken;                       // Last instruction accepted.

    always_ff @(posedge clk) begin
        if (reset) begin
            last_taken <= 1'b0;
        end else if (instr_valid && instr_ready && instr.last) begin
            last_taken <= 1'b1;
        end
    end

    corners_ordered: assert property (@(posedge clk) disable iff (reset)
        instr_valid && instr_ready |->
            (instr.start_row <= instr.end_row) && (instr.start_col <= instr.end_col))
        else begin
            failures++;
            $error("Instruction accepted with start corner past end corner");
        end

    done_holds: assert property (@(posedge clk) disable iff (reset)
        count_done |=> count_done)
        else begin
            failures++;
            $error("count_done fell before reset");
        end

    ready_low_in_sweep: assert property (@(posedge clk) disable iff (reset)
        last_taken |-> !instr_ready)
        else begin
            failures++;
            $error("instr_ready high after the last instruction");
        end

endmodule

bind light_display light_grid_assertions u_assertions (
    .clk        (clk),
    .reset      (reset),
    .instr      (instr),
    .instr_valid(instr_valid),
    .instr_ready(instr_ready),
    .count_done (count_done)
);

/* test/light_grid_tb.sv */
module light_grid_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import light_grid_pkg::*;

    localparam int    grid_rows  = 64;
    localparam int    grid_cols  = 96;
    localparam int    fifo_depth = 4;
    localparam string stim_path  = "test/light_grid_stim.txt";

    logic        clk;
    logic        reset;
    reg_addr_t   awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    reg_addr_t   araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;

    grid_instr_t instr_q[$];
    int          run_len_q[$];                  // Instructions per run.
    int          expect_q[$];
    int          seed         = 32'h5988edb8;
    int          value_errors = 0;
    int          resp_errors  = 0;
    int          limit_cycles = 0;

    light_grid_top #(
        .grid_rows (grid_rows),
        .grid_cols (grid_cols),
        .fifo_depth(fifo_depth)
    ) DUT (
        .clk    (clk),
        .reset  (reset),
        .awaddr (awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata  (wdata),
        .wvalid (wvalid),
        .wready (wready),
        .bresp  (bresp),
        .bvalid (bvalid),
        .bready (bready),
        .araddr (araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata  (rdata),
        .rresp  (rresp),
        .rvalid (rvalid),
        .rready (rready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ##########################################################
    // Bus tasks
    // ##########################################################

    task automatic apply_reset();
        reset <= 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic write_register(input reg_addr_t addr, input logic [31:0] data);
        int delay;
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        @(posedge clk);
        while (!awready) @(posedge clk);
        if (wready !== 1'b1) begin
            resp_errors++;
            $display("CHECK FAILED at %0t: write to 0x%02h took AW without W", $time, addr);
        end
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        delay = $random(seed) & 3;                // Random bready stall.
        repeat (delay) @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        while (!bvalid) @(posedge clk);
        bready <= 1'b0;
        if (bresp != axi_resp_okay) begin
            resp_errors++;
            $display("CHECK FAILED at %0t: write to 0x%02h got bresp %0d", $time, addr, bresp);
        end
    endtask

    task automatic read_register(input reg_addr_t addr, output logic [31:0] data);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(posedge clk);
        while (!arready) @(posedge clk);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        @(posedge clk);
        while (!rvalid) @(posedge clk);
        rready <= 1'b0;
        data = rdata;
        if (rresp != axi_resp_okay) begin
            resp_errors++;
            $display("CHECK FAILED at %0t: read of 0x%02h got rresp %0d", $time, addr, rresp);
        end
    endtask

    task automatic send_instruction(input grid_instr_t ins);
        write_register(reg_start, {ins.start_row, ins.start_col});
        write_register(reg_end, {ins.end_row, ins.end_col});
        write_register(reg_command, {29'd0, ins.last, ins.op});   // Pushes the instruction.
    endtask

    task automatic wait_for_done(output logic [31:0] status);
        status = '0;
        while (status[status_done_bit] !== 1'b1) begin
            read_register(reg_status, status);
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          op, r0, c0, r1, c1, last, count, run_len;
        string       line;
        grid_instr_t entry;
        fd = $fopen(stim_path, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", stim_path);
        end else begin
            run_len = 0;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if ($sscanf(line, "i %d %d %d %d %d %d", op, r0, c0, r1, c1, last) == 6) begin
                    entry.last      = last[0];
                    entry.op        = grid_op_t'(op[1:0]);
                    entry.start_row = pos_t'(r0);
                    entry.start_col = pos_t'(c0);
                    entry.end_row   = pos_t'(r1);
                    entry.end_col   = pos_t'(c1);
                    instr_q.push_back(entry);
                    run_len++;
                end else if ($sscanf(line, "e %d", count) == 1) begin
                    expect_q.push_back(count);
                    run_len_q.push_back(run_len);
                    run_len = 0;
                end
            end
            $fclose(fd);
        end
    endtask

    // ##########################################################
    // Main sequence
    // ##########################################################

    initial begin
        logic [31:0] status;
        logic [31:0] count;
        int          base;
        reset   = 1'b1;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        load_stimulus();
        if (expect_q.size() == 0) begin
            value_errors++;
            $display("The stimulus file holds no complete run");
        end
        // Two cycles per rectangle row plus clear and count sweeps, doubled.
        limit_cycles = 2 * (expect_q.size() * (2 * grid_rows + 69) +
                            instr_q.size() * (2 * grid_rows + 30)) + 100;
        base = 0;
        for (int run = 0; run < expect_q.size(); run++) begin
            apply_reset();
            read_register(reg_status, status);
            if (status[status_busy_bit] !== 1'b1) begin
                value_errors++;
                $display("CHECK FAILED at %0t: run %0d status 0x%08h not busy in clear sweep",
                         $time, run, status);
            end
            for (int i = 0; i < run_len_q[run]; i++) begin
                send_instruction(instr_q[base + i]);
            end
            base += run_len_q[run];
            read_register(reg_status, status);
            if (status[status_busy_bit] !== 1'b1 || status[status_done_bit] !== 1'b0) begin
                value_errors++;
                $display("CHECK FAILED at %0t: run %0d status 0x%08h after last write",
                         $time, run, status);
            end
            wait_for_done(status);
            if (status !== 32'h1) begin
                value_errors++;
                $display("CHECK FAILED at %0t: run %0d final status 0x%08h, expected 0x1",
                         $time, run, status);
            end
            read_register(reg_count, count);
            if (count !== 32'(expect_q[run])) begin
                value_errors++;
                $display("CHECK FAILED at %0t: run %0d count %0d, expected %0d",
                         $time, run, count, expect_q[run]);
            end
        end
        $display("Errors: %0d value, %0d response, %0d assertion",
                 value_errors, resp_errors, DUT.u_display.u_assertions.failures);
        if (value_errors == 0 && resp_errors == 0 &&
            DUT.u_display.u_assertions.failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: no result after %0d clock cycles", limit_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

/* test/light_grid_stim.txt */
# i op start_row start_col end_row end_col last   (op: 0 off, 1 toggle, 3 on)
# e expected_lit_count                            (ends a run, reset follows)
# Run 1: one cell off right after the clear sweep.
i 0 0 0 0 0 1
e 0
# Run 2: whole 64 x 96 grid on.
i 3 0 0 63 95 1
e 6144
# Run 3: rectangle on, overlapping rectangle toggled.
i 3 10 10 19 29 0
i 1 15 20 24 39 1
e 300
# Run 4: bank crossings and the last column.
i 3 5 30 8 65 0
i 3 40 90 63 95 0
i 1 0 95 63 95 1
e 304
# Run 5: burst deeper than the FIFO.
i 3 0 0 63 95 0
i 0 0 0 31 95 0
i 1 0 0 63 31 0
i 0 32 32 63 63 0
i 3 10 10 10 90 0
i 1 0 95 63 95 0
i 0 63 0 63 95 0
i 1 20 40 25 50 1
e 2142

/* flist.f */
source/light_grid_pkg.sv
source/light_grid_ram.sv
source/instr_fifo.sv
source/axil_instr_port.sv
source/light_display.sv
source/light_grid_top.sv
test/light_grid_assertions.sv
test/light_grid_tb.sv

/* Makefile */
SOURCES := $(shell cat flist.f)

.PHONY: all run clean

all: run

obj_dir/Vlight_grid_tb: flist.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module light_grid_tb -f flist.f

run: obj_dir/Vlight_grid_tb test/light_grid_stim.txt
	./obj_dir/Vlight_grid_tb | tee sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "Simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "Test passed" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
